//--- logic/cim_pkg.sv
`default_nettype none

package cim_pkg;

    // Crossbar geometry
    localparam int XBAR_ROWS   = 8;                      // One row per layer input
    localparam int XBAR_COLS   = 4;                      // One column per layer output
    localparam int DATA_SIZE   = 4;                      // Activation bits = iterations
    localparam int WEIGHT_SIZE = 4;                      // Signed weight bits
    localparam int BUS_WIDTH   = 4;                      // Row-driver bits per address
    localparam int NUM_ADDR    = XBAR_ROWS / BUS_WIDTH;
    localparam int ADDR_WIDTH  = 1;

    // Covers -960 .. 840 after all bit planes
    localparam int ACC_WIDTH   = 12;

    typedef logic signed [WEIGHT_SIZE-1:0] weight_t;
    typedef logic signed [ACC_WIDTH-1:0]   acc_t;

    // All weights of one crossbar row, column 0 in the low bits
    typedef struct packed {
        weight_t [XBAR_COLS-1:0] w;
    } weight_row_t;

    // One accumulator per column
    typedef struct packed {
        acc_t [XBAR_COLS-1:0] val;
    } acc_vec_t;

endpackage

`default_nettype wire

//--- logic/fc_pkg.sv
`default_nettype none

package fc_pkg;

    // Layer input vector, activation r drives crossbar row r
    typedef logic [cim_pkg::DATA_SIZE-1:0] act_t;

    typedef struct packed {
        act_t [cim_pkg::XBAR_ROWS-1:0] val;
    } act_vec_t;

    // Output scaling
    localparam int OUT_SIZE  = 8;
    localparam int OUT_SHIFT = 2;                        // Arithmetic shift after ReLU
    localparam int OUT_MAX   = (1 << OUT_SIZE) - 1;      // Saturation limit

    typedef logic [OUT_SIZE-1:0] out_t;

    typedef struct packed {
        out_t [cim_pkg::XBAR_COLS-1:0] val;
    } out_vec_t;

    // Iteration controller states
    typedef enum logic [1:0] {
        idle,
        consume,
        start_cim,
        wait_cim
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/fc_ctrl.sv
`default_nettype none

module fc_ctrl (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            i_start,
    input  wire                            i_cim_ready,
    input  wire                            i_func_ready,
    output logic                           o_ready,
    output logic                           o_shift_enable,
    output logic                           o_cim_we,
    output logic                           o_cim_start,
    output logic                           o_func_start,
    output logic [cim_pkg::ADDR_WIDTH-1:0] o_addr
);
    import cim_pkg::*;
    import fc_pkg::*;

    localparam int ITER_BITS = $clog2(DATA_SIZE);

    ctrl_state_t           state, state_next;
    logic [ITER_BITS-1:0]  iter, iter_next;             // Current bit plane
    logic [ADDR_WIDTH-1:0] addr, addr_next;

    assign o_addr = addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            iter  <= '0;
            addr  <= '0;
        end else begin
            state <= state_next;
            iter  <= iter_next;
            addr  <= addr_next;
        end
    end

    always_comb begin
        state_next     = state;
        iter_next      = iter;
        addr_next      = addr;
        o_ready        = 1'b0;
        o_shift_enable = 1'b0;
        o_cim_we       = 1'b0;
        o_cim_start    = 1'b0;
        o_func_start   = 1'b0;

        case (state)
            idle: begin
                o_ready   = 1'b1;
                iter_next = '0;
                addr_next = '0;
                if (i_start && i_cim_ready) begin   // Vector accepted
                    state_next = consume;
                end
            end

            consume: begin                          // One chunk per address
                o_cim_we = 1'b1;
                if (addr == ADDR_WIDTH'(NUM_ADDR - 1)) begin
                    state_next = start_cim;
                end else begin
                    addr_next = addr + 1'b1;
                end
            end

            start_cim: begin
                addr_next = '0;
                if (!i_cim_ready) begin             // Tile took the start
                    state_next = wait_cim;
                end else begin
                    o_cim_start = 1'b1;
                end
            end

            wait_cim: begin
                addr_next = '0;
                if (i_cim_ready) begin
                    if (iter == ITER_BITS'(DATA_SIZE - 1)) begin
                        // Hand the last plane's sums to a free function unit
                        if (i_func_ready) begin
                            o_func_start = 1'b1;
                            state_next   = idle;
                        end
                    end else begin
                        o_shift_enable = 1'b1;      // Next bit plane
                        iter_next      = iter + 1'b1;
                        state_next     = consume;
                    end
                end
            end

            default: begin
                iter_next  = '0;
                addr_next  = '0;
                state_next = idle;
            end
        endcase
    end

    // Tile goes busy right after it samples the start
    cim_start_taken: assert property (
        @(posedge clk) disable iff (rst) o_cim_start |=> !i_cim_ready
    ) else $error("Crossbar start not taken by the tile");

endmodule

`default_nettype wire

//--- logic/fc_ibuf.sv
`default_nettype none

module fc_ibuf (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            i_capture,
    input  wire fc_pkg::act_vec_t          i_act,
    input  wire                            i_shift_enable,
    input  wire [cim_pkg::ADDR_WIDTH-1:0]  i_addr,
    output logic [cim_pkg::BUS_WIDTH-1:0]  o_rd_chunk
);
    import cim_pkg::*;
    import fc_pkg::*;

    act_vec_t             acts;
    logic [XBAR_ROWS-1:0] plane;                        // Current bit plane, one bit per row

    always_ff @(posedge clk) begin
        if (rst) begin
            acts <= '0;
        end else if (i_capture) begin
            acts <= i_act;
        end else if (i_shift_enable) begin
            // Move the next lower bit into the MSB position
            for (int r = 0; r < XBAR_ROWS; r++) begin
                acts.val[r] <= {acts.val[r][DATA_SIZE-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        for (int r = 0; r < XBAR_ROWS; r++) begin
            plane[r] = acts.val[r][DATA_SIZE-1];        // MSB first
        end
    end

    // Address picks rows addr*BUS_WIDTH upwards
    assign o_rd_chunk = plane[int'(i_addr) * BUS_WIDTH +: BUS_WIDTH];

endmodule

`default_nettype wire

//--- logic/cim_tile.sv
`default_nettype none

module cim_tile (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  i_w_we,
    input  wire [$clog2(cim_pkg::XBAR_ROWS)-1:0] i_w_row,
    input  wire cim_pkg::weight_row_t            i_w_data,
    input  wire                                  i_cim_we,
    input  wire [cim_pkg::ADDR_WIDTH-1:0]        i_addr,
    input  wire [cim_pkg::BUS_WIDTH-1:0]         i_rd_chunk,
    input  wire                                  i_cim_start,
    input  wire                                  i_acc_clear,
    output logic                                 o_cim_ready,
    output cim_pkg::acc_vec_t                    o_acc
);
    import cim_pkg::*;

    localparam int ROW_BITS = $clog2(XBAR_ROWS);

    weight_row_t          weights [XBAR_ROWS];          // Crossbar contents
    logic [XBAR_ROWS-1:0] rd_buf;                       // Row-driver buffer
    logic                 busy;
    logic [ROW_BITS-1:0]  row;                          // Row under evaluation
    acc_vec_t             psum, psum_next;              // Column sums of this bit plane

    assign o_cim_ready = !busy;

    always_ff @(posedge clk) begin
        if (i_w_we) begin
            weights[i_w_row] <= i_w_data;
        end
        if (i_cim_we) begin
            rd_buf[int'(i_addr) * BUS_WIDTH +: BUS_WIDTH] <= i_rd_chunk;
        end
    end

    // Add the current row where its driver bit is set
    always_comb begin
        psum_next = psum;
        if (rd_buf[row]) begin
            for (int c = 0; c < XBAR_COLS; c++) begin
                psum_next.val[c] = psum.val[c] + acc_t'($signed(weights[row].w[c]));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            row   <= '0;
            o_acc <= '0;
        end else if (busy) begin
            psum <= psum_next;
            row  <= row + 1'b1;
            if (row == ROW_BITS'(XBAR_ROWS - 1)) begin
                busy <= 1'b0;
                // MSB-first shift-add over the bit planes
                for (int c = 0; c < XBAR_COLS; c++) begin
                    o_acc.val[c] <= (o_acc.val[c] <<< 1) + psum_next.val[c];
                end
            end
        end else if (i_cim_start) begin
            busy <= 1'b1;
            row  <= '0;
            psum <= '0;
        end else if (i_acc_clear) begin
            o_acc <= '0;                                // Results taken by function unit
        end
    end

    no_rd_write_busy: assert property (
        @(posedge clk) disable iff (rst) busy |-> !i_cim_we
    ) else $error("Row-driver write while crossbar busy");

    no_w_write_busy: assert property (
        @(posedge clk) disable iff (rst) busy |-> !i_w_we
    ) else $error("Weight write while crossbar busy");

endmodule

`default_nettype wire

//--- logic/fc_func.sv
`default_nettype none

module fc_func (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_func_start,
    input  wire cim_pkg::acc_vec_t   i_acc,
    output logic                     o_func_ready,
    output logic                     o_out_valid,
    output fc_pkg::out_vec_t         o_out
);
    import cim_pkg::*;
    import fc_pkg::*;

    localparam int COL_BITS = $clog2(XBAR_COLS);

    acc_vec_t            acc_q;                         // Captured accumulators
    logic                busy;
    logic [COL_BITS-1:0] col;
    acc_t                cur;
    acc_t                scaled;
    out_t                res;

    assign o_func_ready = !busy;

    always_comb begin
        cur    = acc_q.val[col];
        scaled = cur >>> OUT_SHIFT;
        if (cur[ACC_WIDTH-1]) begin
            res = '0;                                   // ReLU
        end else if (scaled > acc_t'(OUT_MAX)) begin
            res = OUT_SIZE'(OUT_MAX);                   // Saturate
        end else begin
            res = scaled[OUT_SIZE-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            col         <= '0;
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= 1'b0;
            if (busy) begin
                o_out.val[col] <= res;                  // One column per cycle
                col            <= col + 1'b1;
                if (col == COL_BITS'(XBAR_COLS - 1)) begin
                    busy        <= 1'b0;
                    o_out_valid <= 1'b1;
                end
            end else if (i_func_start) begin
                busy  <= 1'b1;
                col   <= '0;
                acc_q <= i_acc;
            end
        end
    end

    no_start_busy: assert property (
        @(posedge clk) disable iff (rst) busy |-> !i_func_start
    ) else $error("Function unit started while busy");

endmodule

`default_nettype wire

//--- logic/fc_layer.sv
`default_nettype none

module fc_layer (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  i_start,
    input  wire fc_pkg::act_vec_t                i_act,
    input  wire                                  i_w_we,
    input  wire [$clog2(cim_pkg::XBAR_ROWS)-1:0] i_w_row,
    input  wire cim_pkg::weight_row_t            i_w_data,
    output logic                                 o_ready,
    output logic                                 o_out_valid,
    output fc_pkg::out_vec_t                     o_out
);
    import cim_pkg::*;

    logic                  shift_enable;
    logic                  cim_we;
    logic                  cim_start;
    logic                  cim_ready;
    logic                  func_start;
    logic                  func_ready;
    logic                  capture;
    logic [ADDR_WIDTH-1:0] addr;
    logic [BUS_WIDTH-1:0]  rd_chunk;
    acc_vec_t              acc;

    // Same acceptance condition as the controller leaving idle
    assign capture = i_start && o_ready && cim_ready;

    fc_ctrl fc_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .i_start        (i_start),
        .i_cim_ready    (cim_ready),
        .i_func_ready   (func_ready),
        .o_ready        (o_ready),
        .o_shift_enable (shift_enable),
        .o_cim_we       (cim_we),
        .o_cim_start    (cim_start),
        .o_func_start   (func_start),
        .o_addr         (addr)
    );

    fc_ibuf fc_ibuf_i (
        .clk            (clk),
        .rst            (rst),
        .i_capture      (capture),
        .i_act          (i_act),
        .i_shift_enable (shift_enable),
        .i_addr         (addr),
        .o_rd_chunk     (rd_chunk)
    );

    cim_tile cim_tile_i (
        .clk         (clk),
        .rst         (rst),
        .i_w_we      (i_w_we),
        .i_w_row     (i_w_row),
        .i_w_data    (i_w_data),
        .i_cim_we    (cim_we),
        .i_addr      (addr),
        .i_rd_chunk  (rd_chunk),
        .i_cim_start (cim_start),
        .i_acc_clear (func_start),                      // Cleared as results are taken
        .o_cim_ready (cim_ready),
        .o_acc       (acc)
    );

    fc_func fc_func_i (
        .clk          (clk),
        .rst          (rst),
        .i_func_start (func_start),
        .i_acc        (acc),
        .o_func_ready (func_ready),
        .o_out_valid  (o_out_valid),
        .o_out        (o_out)
    );

endmodule

`default_nettype wire

//--- sim/tb_fc_layer.sv
`default_nettype none

module tb_fc_layer;
    import cim_pkg::*;
    import fc_pkg::*;

    localparam int NUM_VEC   = 6;
    localparam int VEC_BASE  = XBAR_ROWS;               // Vector pairs follow the weight rows
    localparam int MEM_WORDS = XBAR_ROWS + 2 * NUM_VEC;
    localparam int ROW_BITS  = $clog2(XBAR_ROWS);
    localparam int TIMEOUT   = 500;                     // Cycles per wait
    localparam int QUIET     = 100;                     // Longer than one full vector

    logic                clk;
    logic                rst;
    logic                i_start;
    act_vec_t            i_act;
    logic                i_w_we;
    logic [ROW_BITS-1:0] i_w_row;
    weight_row_t         i_w_data;
    logic                o_ready;
    logic                o_out_valid;
    out_vec_t            o_out;

    logic [31:0]         golden [MEM_WORDS];
    integer              seed;
    ctrl_state_t         dbg_state;

    assign dbg_state = fc_layer_i.fc_ctrl_i.state;      // Shown on timeouts

    fc_layer fc_layer_i (
        .clk         (clk),
        .rst         (rst),
        .i_start     (i_start),
        .i_act       (i_act),
        .i_w_we      (i_w_we),
        .i_w_row     (i_w_row),
        .i_w_data    (i_w_data),
        .o_ready     (o_ready),
        .o_out_valid (o_out_valid),
        .o_out       (o_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s, controller in %s", what, dbg_state.name());
        $display("Done: errors found");
        $fatal(1, "Stopped on timeout");
    endtask

    task automatic load_weights();
        for (int r = 0; r < XBAR_ROWS; r++) begin
            @(posedge clk);
            i_w_we   <= 1'b1;
            i_w_row  <= ROW_BITS'(r);
            i_w_data <= weight_row_t'(golden[r][$bits(weight_row_t)-1:0]);
        end
        @(posedge clk);
        i_w_we <= 1'b0;
    endtask

    // Returns on a falling edge with o_ready high
    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_ready && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (!o_ready) begin
            report_timeout("o_ready");
        end
    endtask

    task automatic pulse_start(input act_vec_t act);
        @(posedge clk);
        i_start <= 1'b1;
        i_act   <= act;
        @(posedge clk);
        i_start <= 1'b0;
    endtask

    // Returns on the falling edge inside the valid pulse
    task automatic wait_for_valid();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_out_valid && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (!o_out_valid) begin
            report_timeout("o_out_valid");
        end
    endtask

    task automatic expect_no_valid(input int cycles);
        int pulses;
        pulses = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (o_out_valid) begin
                pulses++;
            end
        end
        check_value("extra o_out_valid pulses", 32'd0, pulses);
    endtask

    initial begin
        int gap;
        rst      = 1'b1;
        i_start  = 1'b0;
        i_act    = '0;
        i_w_we   = 1'b0;
        i_w_row  = '0;
        i_w_data = '0;
        seed     = 80313;
        $readmemh("sim/fc_layer_golden.txt", golden);

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        repeat (20) begin                               // Quiet idle after reset
            @(negedge clk);
            check_value("ready after reset", 32'd1, o_ready);
            check_value("no valid after reset", 32'd0, o_out_valid);
        end

        load_weights();

        // Back-to-back vectors also prove the accumulators clear between starts
        for (int k = 0; k < NUM_VEC; k++) begin
            gap = $unsigned($random(seed)) % 6;
            repeat (gap) @(posedge clk);
            wait_for_ready();
            pulse_start(act_vec_t'(golden[VEC_BASE + 2 * k]));
            wait_for_valid();
            check_value($sformatf("vector %0d", k), golden[VEC_BASE + 2 * k + 1], o_out);
        end

        // Second start lands while busy and must be dropped
        gap = $unsigned($random(seed)) % 6;
        repeat (gap) @(posedge clk);
        wait_for_ready();
        pulse_start(act_vec_t'(golden[VEC_BASE + 8]));
        repeat (3) @(negedge clk);
        check_value("ready low while busy", 32'd0, o_ready);
        pulse_start(act_vec_t'(golden[VEC_BASE + 2]));
        wait_for_valid();
        check_value("start during busy", golden[VEC_BASE + 9], o_out);
        expect_no_valid(QUIET);
        check_value("ready after busy start", 32'd1, o_ready);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- fc_layer.f
logic/cim_pkg.sv
logic/fc_pkg.sv
logic/fc_ctrl.sv
logic/fc_ibuf.sv
logic/cim_tile.sv
logic/fc_func.sv
logic/fc_layer.sv
sim/tb_fc_layer.sv

//--- Makefile
# Verilator simulation of the fully connected CIM layer
VERILATOR ?= verilator
TOP       ?= tb_fc_layer
FILELIST  ?= fc_layer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_EXE   ?= V$(TOP)

.PHONY: sim clean

# The simulator exits non-zero on $fatal, which fails this target
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_EXE)
	./$(BUILD_DIR)/$(SIM_EXE)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/fc_layer_golden.txt
// Lines 1-8: weight_row_t for rows 0..7, column 0 in the low nibble
// Then one vector per line: act_vec_t (row 0 low nibble), expected out_vec_t (column 0 low byte)
0000F187
00002E87
00004387
00006C87
0000D587
00001A87
0000B787
00003087
// All-zero activations
00000000 00000000
// Maximum activations, column 0 all +7
FFFFFFFF 1A0F00D2
// Negative sums in columns 1 and 2
00A00003 01000016
// Row 2 only in the MSB plane, row 7 only in the LSB plane
10000800 0806000F
// Mixed activations
6B37E295 0C070063
// Sparse high activations
1F000F0F 00290050
